// File: common/mtimer_pkg.sv
// Gray width, control bit positions, register addresses, bus structs, update states, Gray helpers.
`default_nettype none

package mtimer_pkg;

	localparam int gray_width = 4; // low mtime bits kept in Gray code.

	localparam int ctrl_stop_bit = 0;
	localparam int ctrl_irq_en_bit = 1;

	// word addresses on the register bus.
	typedef enum logic [2:0] {
		addr_mtime_lo    = 3'd0,
		addr_mtime_hi    = 3'd1,
		addr_mtimecmp_lo = 3'd2,
		addr_mtimecmp_hi = 3'd3,
		addr_ctrl        = 3'd4
	} reg_addr_e;

	typedef struct packed {
		logic        write;
		reg_addr_e   addr;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic [31:0] rdata;
	} bus_rsp_t;

	typedef enum logic [1:0] {
		upd_idle,
		upd_req,
		upd_drop
	} upd_state_e;

	function automatic logic [gray_width-1:0] bin2gray(input logic [gray_width-1:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	// each binary bit is the xor of all Gray bits at and above it.
	function automatic logic [gray_width-1:0] gray2bin(input logic [gray_width-1:0] gray);
		logic [gray_width-1:0] bin;
		bin[gray_width-1] = gray[gray_width-1];
		for (int i = gray_width - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage

`default_nettype wire

// File: rtc/mtime_counter.sv
// Machine timer counter with Gray-coded low bits, shadow load on update request and stop control.
`default_nettype none

module mtime_counter (
	input  wire                               mtime_clk,
	input  wire                               por_rstn,
	input  wire [63:mtimer_pkg::gray_width]   mtime_shadow,
	input  wire [mtimer_pkg::gray_width-1:0]  mtime_shadow_gray,
	input  wire                               stoptime,
	input  wire                               update_req,
	output logic                              update_ack,
	output logic [63:0]                       mtime_value
);

	logic                              ack_q;
	logic [63:mtimer_pkg::gray_width]  upper_q;
	logic [mtimer_pkg::gray_width-1:0] gray_q;
	logic [mtimer_pkg::gray_width-1:0] gray_bin;
	logic [mtimer_pkg::gray_width-1:0] gray_next;
	logic                              load;
	logic                              wrap;

	// the request is seen as new only on the cycle before the ack comes back.
	assign load = update_req & ~ack_q;

	assign gray_bin = mtimer_pkg::gray2bin(gray_q);

	// upper part steps when the low part is about to roll over.
	assign wrap = (&gray_bin) & ~stoptime;

	always_comb begin
		if (load) begin
			gray_next = mtime_shadow_gray;
		end else begin
			gray_next = mtimer_pkg::bin2gray(gray_bin + {{(mtimer_pkg::gray_width-1){1'b0}}, 1'b1});
		end
	end

	always_ff @(posedge mtime_clk or negedge por_rstn) begin
		if (!por_rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= update_req; // ack is the request one clock later.
		end
	end

	always_ff @(posedge mtime_clk or negedge por_rstn) begin
		if (!por_rstn) begin
			gray_q <= '0;
		end else if (load || !stoptime) begin
			gray_q <= gray_next;
		end
	end

	always_ff @(posedge mtime_clk or negedge por_rstn) begin
		if (!por_rstn) begin
			upper_q <= '0;
		end else if (load) begin
			upper_q <= mtime_shadow; // a load wins over stop and counting.
		end else if (wrap) begin
			upper_q <= upper_q + {{(63-mtimer_pkg::gray_width){1'b0}}, 1'b1};
		end
	end

	assign update_ack = ack_q;

	assign mtime_value = {upper_q, gray_bin};

endmodule

`default_nettype wire

// File: hdl/mtimer_regs.sv
// Register block with bus decode, mtime shadow, update handshake FSM, ctrl, mtimecmp and read snapshot.
`default_nettype none

module mtimer_regs (
	input  wire                               mtime_clk,
	input  wire                               por_rstn,
	input  wire                               req_valid,
	input  wire mtimer_pkg::bus_req_t         req,
	input  wire [63:0]                        mtime_value,
	input  wire                               update_ack,
	output logic                              req_ready,
	output logic                              rsp_valid,
	output mtimer_pkg::bus_rsp_t              rsp,
	output logic                              update_req,
	output logic [63:mtimer_pkg::gray_width]  mtime_shadow,
	output logic [mtimer_pkg::gray_width-1:0] mtime_shadow_gray,
	output logic                              stoptime,
	output logic [63:0]                       mtimecmp,
	output logic                              irq_en
);

	mtimer_pkg::upd_state_e upd_state;
	mtimer_pkg::upd_state_e upd_next;

	logic [1:0]  ctrl_q;
	logic [31:0] lo_pend_q;
	logic [31:0] snap_hi_q;
	logic [31:0] rdata_next;
	logic        req_fire;
	logic        wr;
	logic        rd;
	logic        hi_write;

	assign req_ready = (upd_state == mtimer_pkg::upd_idle);
	assign req_fire = req_valid & req_ready;
	assign wr = req_fire & req.write;
	assign rd = req_fire & ~req.write;
	assign hi_write = wr & (req.addr == mtimer_pkg::addr_mtime_hi);

	always_comb begin
		upd_next = upd_state;
		case (upd_state)
			mtimer_pkg::upd_idle: begin
				if (hi_write) begin
					upd_next = mtimer_pkg::upd_req;
				end
			end
			mtimer_pkg::upd_req: begin
				if (update_ack) begin
					upd_next = mtimer_pkg::upd_drop;
				end
			end
			// the ack follows the request by one clock, so it is low by the next edge.
			mtimer_pkg::upd_drop: upd_next = mtimer_pkg::upd_idle;
			default: upd_next = mtimer_pkg::upd_idle;
		endcase
	end

	always_ff @(posedge mtime_clk or negedge por_rstn) begin
		if (!por_rstn) begin
			upd_state <= mtimer_pkg::upd_idle;
		end else begin
			upd_state <= upd_next;
		end
	end

	assign update_req = (upd_state == mtimer_pkg::upd_req);

	// the shadow is only written from idle, so it holds while the request is up.
	always_ff @(posedge mtime_clk) begin
		if (wr && req.addr == mtimer_pkg::addr_mtime_lo) begin
			lo_pend_q <= req.wdata;
		end
		if (hi_write) begin
			mtime_shadow <= {req.wdata, lo_pend_q[31:mtimer_pkg::gray_width]};
			mtime_shadow_gray <= mtimer_pkg::bin2gray(lo_pend_q[mtimer_pkg::gray_width-1:0]);
		end
	end

	always_ff @(posedge mtime_clk or negedge por_rstn) begin
		if (!por_rstn) begin
			ctrl_q <= '0;
			mtimecmp <= '1; // no interrupt until software programs a compare value.
		end else if (wr) begin
			case (req.addr)
				mtimer_pkg::addr_ctrl: ctrl_q <= req.wdata[1:0];
				mtimer_pkg::addr_mtimecmp_lo: mtimecmp[31:0] <= req.wdata;
				mtimer_pkg::addr_mtimecmp_hi: mtimecmp[63:32] <= req.wdata;
				default: ;
			endcase
		end
	end

	assign stoptime = ctrl_q[mtimer_pkg::ctrl_stop_bit];
	assign irq_en = ctrl_q[mtimer_pkg::ctrl_irq_en_bit];

	always_comb begin
		rdata_next = '0;
		case (req.addr)
			mtimer_pkg::addr_mtime_lo: rdata_next = mtime_value[31:0];
			mtimer_pkg::addr_mtime_hi: rdata_next = snap_hi_q;
			mtimer_pkg::addr_mtimecmp_lo: rdata_next = mtimecmp[31:0];
			mtimer_pkg::addr_mtimecmp_hi: rdata_next = mtimecmp[63:32];
			mtimer_pkg::addr_ctrl: rdata_next = {30'b0, ctrl_q};
			default: rdata_next = '0;
		endcase
	end

	// low read freezes the matching high word so a 64-bit read stays coherent.
	always_ff @(posedge mtime_clk) begin
		if (rd && req.addr == mtimer_pkg::addr_mtime_lo) begin
			snap_hi_q <= mtime_value[63:32];
		end
		if (rd) begin
			rsp.rdata <= rdata_next;
		end
	end

	always_ff @(posedge mtime_clk or negedge por_rstn) begin
		if (!por_rstn) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= rd; // one-cycle pulse per accepted read.
		end
	end

endmodule

`default_nettype wire

// File: hdl/mtimecmp_irq.sv
// Timer interrupt from an unsigned compare of mtime against mtimecmp.
`default_nettype none

module mtimecmp_irq (
	input  wire        mtime_clk,
	input  wire        por_rstn,
	input  wire [63:0] mtime_value,
	input  wire [63:0] mtimecmp,
	input  wire        irq_en,
	output logic       timer_irq
);

	logic reached;

	// pending as long as mtime is at or past the compare value.
	assign reached = (mtime_value >= mtimecmp);

	always_ff @(posedge mtime_clk or negedge por_rstn) begin
		if (!por_rstn) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= reached & irq_en;
		end
	end

endmodule

`default_nettype wire

// File: hdl/mtimer_top.sv
// Machine timer top level joining the register block, the mtime counter and the comparator.
`default_nettype none

module mtimer_top (
	input  wire                       mtime_clk,
	input  wire                       por_rstn,
	input  wire                       req_valid,
	input  wire mtimer_pkg::bus_req_t req,
	output logic                      req_ready,
	output logic                      rsp_valid,
	output mtimer_pkg::bus_rsp_t      rsp,
	output logic                      timer_irq
);

	wire                              update_req;
	wire                              update_ack;
	wire [63:mtimer_pkg::gray_width]  mtime_shadow;
	wire [mtimer_pkg::gray_width-1:0] mtime_shadow_gray;
	wire                              stoptime;
	wire [63:0]                       mtime_value;
	wire [63:0]                       mtimecmp;
	wire                              irq_en;

	mtimer_regs i_mtimer_regs (
		.mtime_clk         (mtime_clk),
		.por_rstn          (por_rstn),
		.req_valid         (req_valid),
		.req               (req),
		.mtime_value       (mtime_value),
		.update_ack        (update_ack),
		.req_ready         (req_ready),
		.rsp_valid         (rsp_valid),
		.rsp               (rsp),
		.update_req        (update_req),
		.mtime_shadow      (mtime_shadow),
		.mtime_shadow_gray (mtime_shadow_gray),
		.stoptime          (stoptime),
		.mtimecmp          (mtimecmp),
		.irq_en            (irq_en)
	);

	mtime_counter i_mtime_counter (
		.mtime_clk         (mtime_clk),
		.por_rstn          (por_rstn),
		.mtime_shadow      (mtime_shadow),
		.mtime_shadow_gray (mtime_shadow_gray),
		.stoptime          (stoptime),
		.update_req        (update_req),
		.update_ack        (update_ack),
		.mtime_value       (mtime_value)
	);

	mtimecmp_irq i_mtimecmp_irq (
		.mtime_clk   (mtime_clk),
		.por_rstn    (por_rstn),
		.mtime_value (mtime_value),
		.mtimecmp    (mtimecmp),
		.irq_en      (irq_en),
		.timer_irq   (timer_irq)
	);

endmodule

`default_nettype wire

// File: verif/mtimer_bus_tasks.svh
// Register bus request, write and read tasks, plus 64-bit mtime load and read, for the timer testbench.
`ifndef mtimer_bus_tasks_svh
`define mtimer_bus_tasks_svh

// starts 1 ns after a rising edge and returns 1 ns after the edge that takes the request.
task automatic send_request(input logic write, input mtimer_pkg::reg_addr_e addr,
		input logic [31:0] wdata);
	int waited;
	waited = 0;
	req.write = write;
	req.addr = addr;
	req.wdata = wdata;
	req_valid = 1'b1;
	while (!req_ready) begin
		stall_cycles++;
		waited++;
		if (waited > bus_timeout) begin
			stop_with_error(1'b0, "req_ready stayed low for 100 cycles and the bus is stuck");
		end
		@(posedge mtime_clk);
		#1;
	end
	@(posedge mtime_clk); // ready was high ahead of this edge so the request moves here.
	#1;
	req_valid = 1'b0;
endtask

task automatic bus_write(input mtimer_pkg::reg_addr_e addr, input logic [31:0] wdata);
	send_request(1'b1, addr, wdata);
endtask

// the compare process pops the expected value when the response shows up.
task automatic bus_read(input mtimer_pkg::reg_addr_e addr, input bit check,
		input logic [31:0] expected, output logic [31:0] rdata);
	int unsigned count_before;
	int waited;
	count_before = rsp_count;
	waited = 0;
	exp_q.push_back(expected);
	chk_q.push_back(check);
	send_request(1'b0, addr, 32'h0);
	while (rsp_count == count_before) begin
		waited++;
		if (waited > bus_timeout) begin
			stop_with_error(1'b0, "no read response came back after the read was accepted");
		end
		@(posedge mtime_clk);
		#1;
	end
	rdata = last_rdata;
endtask

task automatic read_mtime(output logic [63:0] value);
	logic [31:0] lo;
	logic [31:0] hi;
	bus_read(mtimer_pkg::addr_mtime_lo, 1'b0, 32'h0, lo);
	bus_read(mtimer_pkg::addr_mtime_hi, 1'b0, 32'h0, hi); // returns the snapshot of the low read.
	value = {hi, lo};
endtask

task automatic load_mtime(input logic [63:0] value);
	bus_write(mtimer_pkg::addr_mtime_lo, value[31:0]);
	bus_write(mtimer_pkg::addr_mtime_hi, value[63:32]);
endtask

`endif

// File: verif/mtimer_tb.sv
// Machine timer testbench with clock, reset, register model, mtime window check and scenarios.
`default_nettype none

module mtimer_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int bus_timeout = 100;
	localparam int mtime_slack = 4; // stamps are taken a few edges away from the bus edge.

	logic                 mtime_clk = 1'b0;
	logic                 por_rstn;
	logic                 req_valid;
	mtimer_pkg::bus_req_t req;
	logic                 req_ready;
	logic                 rsp_valid;
	mtimer_pkg::bus_rsp_t rsp;
	logic                 timer_irq;

	int          seed = 56977;
	int unsigned cycle_count;
	int unsigned rsp_count = 0;
	int unsigned stall_cycles = 0;
	logic [31:0] last_rdata;
	logic [31:0] exp_q[$];
	bit          chk_q[$];
	logic [1:0]  model_ctrl;
	logic [63:0] model_cmp;

	mtimer_top i_mtimer_top (
		.mtime_clk (mtime_clk),
		.por_rstn  (por_rstn),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.timer_irq (timer_irq)
	);

	always #5 mtime_clk = ~mtime_clk;

	always @(posedge mtime_clk or negedge por_rstn) begin
		if (!por_rstn) begin
			cycle_count <= 0;
		end else begin
			cycle_count <= cycle_count + 1;
		end
	end

	task automatic stop_with_error(input bit value_error, input string msg);
		if (value_error) begin
			$display("[FAIL] %0t ns: %s", $time, msg);
		end else begin
			$display("%s", msg);
		end
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	`include "mtimer_bus_tasks.svh"

	function automatic logic [31:0] ref_readback(input mtimer_pkg::reg_addr_e addr);
		logic [31:0] value;
		case (addr)
			mtimer_pkg::addr_ctrl: value = {30'b0, model_ctrl};
			mtimer_pkg::addr_mtimecmp_lo: value = model_cmp[31:0];
			mtimer_pkg::addr_mtimecmp_hi: value = model_cmp[63:32];
			default: value = 32'h0;
		endcase
		return value;
	endfunction

	function automatic void ref_write(input mtimer_pkg::reg_addr_e addr, input logic [31:0] data);
		case (addr)
			mtimer_pkg::addr_ctrl: model_ctrl = data[1:0]; // upper ctrl bits are not stored.
			mtimer_pkg::addr_mtimecmp_lo: model_cmp[31:0] = data;
			mtimer_pkg::addr_mtimecmp_hi: model_cmp[63:32] = data;
			default: ;
		endcase
	endfunction

	// a running counter gains at most one per cycle plus the bus slack.
	function automatic bit ref_mtime_window(input logic [63:0] start, input int unsigned n,
			input logic [63:0] value);
		return (value >= start) && (value <= start + 64'(n) + 64'(mtime_slack));
	endfunction

	always @(negedge mtime_clk) begin : compare_responses
		logic [31:0] expected;
		bit check;
		if (por_rstn && rsp_valid) begin
			if (exp_q.size() == 0) begin
				stop_with_error(1'b0, "a read response arrived with no read outstanding");
			end else begin
				expected = exp_q.pop_front();
				check = chk_q.pop_front();
				if (check) begin
					assert (rsp.rdata === expected) else
						stop_with_error(1'b1, $sformatf("read data %h, expected %h",
							rsp.rdata, expected));
				end
				last_rdata = rsp.rdata;
				rsp_count++;
			end
		end
	end

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge mtime_clk);
			#1;
		end
	endtask

	task automatic write_reg(input mtimer_pkg::reg_addr_e addr, input logic [31:0] data);
		ref_write(addr, data);
		bus_write(addr, data);
	endtask

	task automatic check_reg(input mtimer_pkg::reg_addr_e addr);
		logic [31:0] rdata;
		bus_read(addr, 1'b1, ref_readback(addr), rdata);
	endtask

	task automatic check_mtime(input logic [63:0] start, input int unsigned n,
			input logic [63:0] got, input string what);
		assert (ref_mtime_window(start, n, got)) else
			stop_with_error(1'b1, $sformatf("%s mtime %h outside %h plus %0d cycles",
				what, got, start, n));
	endtask

	task automatic check_interrupt();
		logic [63:0] got;
		int waited;
		write_reg(mtimer_pkg::addr_ctrl, 32'h1);
		load_mtime(64'd100);
		write_reg(mtimer_pkg::addr_mtimecmp_lo, 32'd130);
		write_reg(mtimer_pkg::addr_mtimecmp_hi, 32'd0);
		write_reg(mtimer_pkg::addr_ctrl, 32'h3);
		repeat (10) begin
			assert (timer_irq === 1'b0) else
				stop_with_error(1'b1, "timer_irq high while mtime is stopped below mtimecmp");
			idle_cycles(1);
		end
		write_reg(mtimer_pkg::addr_ctrl, 32'h2);
		waited = 0;
		while (timer_irq !== 1'b1) begin
			waited++;
			if (waited > bus_timeout) begin
				stop_with_error(1'b0, "timer_irq never rose after mtime passed mtimecmp");
			end
			idle_cycles(1);
		end
		write_reg(mtimer_pkg::addr_ctrl, 32'h3);
		read_mtime(got);
		assert (got >= 64'd130) else
			stop_with_error(1'b1, $sformatf("interrupt seen with mtime only at %0d", got));
		write_reg(mtimer_pkg::addr_ctrl, 32'h1);
		waited = 0;
		while (timer_irq !== 1'b0) begin
			waited++;
			if (waited > 2) begin
				stop_with_error(1'b0, "timer_irq still high two cycles after irq_en was cleared");
			end
			idle_cycles(1);
		end
	endtask

	task automatic check_random_traffic();
		int sel;
		logic [31:0] data;
		mtimer_pkg::reg_addr_e addr;
		for (int i = 0; i < 50; i++) begin
			sel = {$random(seed)} % 3;
			case (sel)
				0: addr = mtimer_pkg::addr_ctrl;
				1: addr = mtimer_pkg::addr_mtimecmp_lo;
				default: addr = mtimer_pkg::addr_mtimecmp_hi;
			endcase
			data = $random(seed);
			if ($random(seed) & 1) begin
				write_reg(addr, data);
			end else begin
				check_reg(addr);
			end
		end
	endtask

	initial begin
		logic [63:0] got;
		logic [63:0] prev;
		logic [63:0] rnd;
		int unsigned start_cycle;
		int unsigned prev_cycle;
		int unsigned stalls_before;
		por_rstn = 1'b0;
		req_valid = 1'b0;
		req = '0;
		model_ctrl = 2'b00;
		model_cmp = '1;
		repeat (4) @(posedge mtime_clk);
		#1;
		por_rstn = 1'b1;

		check_reg(mtimer_pkg::addr_ctrl);
		check_reg(mtimer_pkg::addr_mtimecmp_lo);
		check_reg(mtimer_pkg::addr_mtimecmp_hi);
		read_mtime(got);
		check_mtime(64'h0, cycle_count, got, "after reset");
		assert (timer_irq === 1'b0) else stop_with_error(1'b1, "timer_irq high after reset");

		write_reg(mtimer_pkg::addr_ctrl, 32'h1);
		rnd = {$random(seed), $random(seed)};
		stalls_before = stall_cycles;
		load_mtime(rnd);
		read_mtime(got);
		assert (got === rnd) else
			stop_with_error(1'b1, $sformatf("mtime %h after a stopped load of %h", got, rnd));
		assert (stall_cycles > stalls_before) else
			stop_with_error(1'b0, "req_ready never went low while the mtime update ran");

		load_mtime(64'h1_ffff_fff0);
		start_cycle = cycle_count;
		write_reg(mtimer_pkg::addr_ctrl, 32'h0);
		idle_cycles(40);
		write_reg(mtimer_pkg::addr_ctrl, 32'h1);
		read_mtime(got);
		check_mtime(64'h1_ffff_fff0, cycle_count - start_cycle, got, "carry");
		assert (got > 64'h2_0000_0000) else
			stop_with_error(1'b1, $sformatf("mtime %h did not carry into the upper part", got));

		// start just below a low word wrap so the pairs cross it.
		load_mtime(64'h0000_0000_ffff_ffc0);
		write_reg(mtimer_pkg::addr_ctrl, 32'h0);
		prev_cycle = cycle_count;
		read_mtime(prev);
		for (int i = 0; i < 24; i++) begin
			idle_cycles($random(seed) & 7);
			start_cycle = cycle_count;
			read_mtime(got);
			check_mtime(prev, start_cycle - prev_cycle, got, "coherent pair");
			prev = got;
			prev_cycle = start_cycle;
		end
		assert (got >= 64'h1_0000_0000) else
			stop_with_error(1'b1, $sformatf("mtime %h never showed the low word wrap", got));

		check_interrupt();
		check_random_traffic();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verif
common/mtimer_pkg.sv
rtc/mtime_counter.sv
hdl/mtimer_regs.sv
hdl/mtimecmp_irq.sv
hdl/mtimer_top.sv
verif/mtimer_tb.sv

// File: Makefile
# Verilator flow for the machine timer.

TOP := mtimer_tb
RTL := common/mtimer_pkg.sv rtc/mtime_counter.sv hdl/mtimer_regs.sv \
	hdl/mtimecmp_irq.sv hdl/mtimer_top.sv

.PHONY: lint sim clean

# lint the synthesizable design on its own.
lint:
	verilator --lint-only -Wall --top-module mtimer_top $(RTL)

# build the testbench and run it; the status follows the pass line in the output.
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f filelist.f
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
